// ==== verif/vc_map_stim.txt ====
# op addr vc value expect; op 0 read, 1 write, 2 cfg, 3 hold rd_out ready low for addr cycles
# vc 0 VA 1 VL0 2 VH0 3 VH1; cfg uses addr as ratio, vc as enable, expect 1 when a fence follows
0 00000000 0 01 1
0 00000010 0 02 3
0 00000011 0 03 2
0 C0000000 0 04 1
0 12345678 0 05 2
1 00000FC0 0 DEADBE06 2
1 80000021 0 A5A5A507 2
1 00000040 2 12345608 2
0 00000011 1 09 1
0 00000000 3 0A 3
2 00000010 0 00 0
0 00000000 0 0B 0
1 00000011 0 1122330C 0
2 00000010 1 00 0
1 00000FC0 0 0000000D 2
1 0000100F 0 0000000E 1
2 00000008 1 00 1
0 0000100F 0 0F 3
0 00000005 0 10 1
3 00000006 0 00 0
0 12345678 0 11 2
0 00000010 0 12 3
0 00000040 0 13 1
2 0000003C 1 00 1
0 12345678 0 14 1
1 00000FC0 0 00000015 2

// ==== build.f ====
+incdir+include
hdl/vc_map_pkg.sv
hdl/vc_map_stage.sv
hdl/req_tracker.sv
hdl/vc_map_ctrl.sv
hdl/vc_map_top.sv
verif/vc_map_tb.sv

// ==== Makefile ====
TOP = vc_map_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Checks failed" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "All checks passed" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== verif/vc_map_tb.sv ====
`timescale 1ns/1ps

module vc_map_tb
    import vc_map_pkg::*;
();

    localparam int OP_RD   = 0;
    localparam int OP_WR   = 1;
    localparam int OP_CFG  = 2;
    localparam int OP_HOLD = 3;

    // Write responses come back only after the fence delay has run out
    // so the fence can leave early only if it ignores the write count
    localparam int WR_RSP_EXTRA = 9;

    // ==================================================
    // DUT ports
    // ==================================================

    logic        clk = 1'b0;
    logic        reset;
    logic        rd_in_valid;
    logic        rd_in_ready;
    t_addr       rd_in_addr;
    t_vc         rd_in_vc;
    t_rd_payload rd_in_payload;
    logic        rd_out_valid;
    logic        rd_out_ready = 1'b1;
    t_addr       rd_out_addr;
    t_vc         rd_out_vc;
    t_rd_payload rd_out_payload;
    logic        wr_in_valid;
    logic        wr_in_ready;
    t_addr       wr_in_addr;
    t_vc         wr_in_vc;
    t_wr_payload wr_in_payload;
    logic        wr_out_valid;
    logic        wr_out_ready = 1'b1;
    t_addr       wr_out_addr;
    t_vc         wr_out_vc;
    t_wr_payload wr_out_payload;
    logic        rd_rsp_valid = 1'b0;
    logic        wr_rsp_valid = 1'b0;
    logic        fence_valid;
    logic        fence_ready = 1'b1;
    logic        fence_rsp_valid = 1'b0;
    logic        cfg_valid;
    logic        cfg_ready;
    t_ratio      cfg_ratio;
    logic        cfg_map_enable;
    logic        map_changed;

    vc_map_top DUT (.*);

    // Stimulus lines, plus the indices of the reads and writes in file order
    int          op_list[$];
    t_addr       addr_list[$];
    int          vc_list[$];
    logic [31:0] val_list[$];
    int          exp_list[$];
    int          rd_ops[$];
    int          wr_ops[$];

    // Bookkeeping of the memory model, which alone writes these
    integer      seed = 51979;
    int          mem_cycle = 0;
    int          rd_due[$];
    int          wr_due[$];
    int          fence_due[$];
    int          rd_ptr = 0;
    int          wr_ptr = 0;
    int          wr_outstanding = 0;
    int          hold_seen = 0;
    int          hold_left = 0;
    int          fences_in_window = 0;
    int          fences_seen = 0;
    int          changes_seen = 0;
    logic        rd_held = 1'b0;
    t_addr       rd_held_addr;
    t_vc         rd_held_vc;
    t_rd_payload rd_held_pl;

    // Written by the stimulus process only
    int          hold_id = 0;
    int          hold_len = 0;
    int          changes_requested = 0;
    int          cycle_limit = 0;

    // Clock cycles seen by the timeout
    int          cycle_count = 0;

    // ==================================================
    // Error reporting and compare tasks
    // ==================================================

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_error(string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_vc(string name, t_vc exp, t_vc act);
        if (exp !== act)
        begin
            $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, t_addr exp, t_addr act);
        if (exp !== act)
        begin
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_payload_rd(string name, t_rd_payload exp, t_rd_payload act);
        if (exp !== act)
        begin
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_payload_wr(string name, t_wr_payload exp, t_wr_payload act);
        if (exp !== act)
        begin
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act)
        begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // The read tag is the value column, a write carries its tag in data bits 7..0
    function automatic t_rd_payload rd_payload_of(int k);
        t_rd_payload p;
        p.tag = val_list[k][7:0];
        return p;
    endfunction

    function automatic t_wr_payload wr_payload_of(int k);
        t_wr_payload p;
        p.tag  = val_list[k][7:0];
        p.data = val_list[k];
        return p;
    endfunction

    // Response gaps of one to four cycles
    function automatic int take_gap();
        return 1 + ($random(seed) & 3);
    endfunction

    // ==================================================
    // Memory model and output monitor
    // ==================================================

    task automatic watch_outputs();
        int  k;
        int  due;
        logic changing;
        changing = (changes_requested != changes_seen);
        if (rd_out_valid && rd_out_ready)
        begin
            if (rd_ptr >= rd_ops.size())
                report_error("a read left the DUT that was never sent");
            k = rd_ops[rd_ptr];
            check_addr("rd_out_addr", addr_list[k], rd_out_addr);
            check_vc("rd_out_vc", t_vc'(exp_list[k]), rd_out_vc);
            check_payload_rd("rd_out_payload", rd_payload_of(k), rd_out_payload);
            rd_ptr++;
            rd_held = 1'b0;
            due = mem_cycle + take_gap();
            if ((rd_due.size() != 0) && (due <= rd_due[$]))
                due = rd_due[$] + 1;
            rd_due.push_back(due);
        end
        else if (rd_out_valid)
        begin
            // A stalled read must sit still until the memory takes it
            if (rd_held)
            begin
                check_addr("rd_out_addr held", rd_held_addr, rd_out_addr);
                check_vc("rd_out_vc held", rd_held_vc, rd_out_vc);
                check_payload_rd("rd_out_payload held", rd_held_pl, rd_out_payload);
            end
            rd_held      = 1'b1;
            rd_held_addr = rd_out_addr;
            rd_held_vc   = rd_out_vc;
            rd_held_pl   = rd_out_payload;
        end
        else
        begin
            rd_held = 1'b0;
        end

        if (wr_out_valid && wr_out_ready)
        begin
            if (wr_ptr >= wr_ops.size())
                report_error("a write left the DUT that was never sent");
            k = wr_ops[wr_ptr];
            check_addr("wr_out_addr", addr_list[k], wr_out_addr);
            check_vc("wr_out_vc", t_vc'(exp_list[k]), wr_out_vc);
            check_payload_wr("wr_out_payload", wr_payload_of(k), wr_out_payload);
            wr_ptr++;
            wr_outstanding++;
            due = mem_cycle + WR_RSP_EXTRA + take_gap();
            if ((wr_due.size() != 0) && (due <= wr_due[$]))
                due = wr_due[$] + 1;
            wr_due.push_back(due);
        end

        // Every write sent before the ratio change has left and been answered
        if (fence_valid && fence_ready)
        begin
            check_bit("fence_valid inside ratio change", 1'b1, changing);
            check_bit("writes retired before fence", 1'b1,
                      (wr_outstanding == 0) && !wr_out_valid);
            fences_in_window++;
            fences_seen++;
            fence_due.push_back(mem_cycle + take_gap());
        end

        if (changing)
        begin
            check_bit("rd_in_ready during ratio change", 1'b0, rd_in_ready);
            check_bit("wr_in_ready during ratio change", 1'b0, wr_in_ready);
        end

        if (map_changed)
        begin
            check_bit("map_changed after ratio cfg", 1'b1, changing);
            check_bit("single fence before map_changed", 1'b1, fences_in_window == 1);
            fences_in_window = 0;
            changes_seen++;
        end
    endtask

    // Ready and response pulses change on the falling edge, outputs are
    // sampled a quarter period later where they are settled
    always @(negedge clk)
    begin
        mem_cycle++;
        if (hold_id != hold_seen)
        begin
            hold_seen = hold_id;
            hold_left = hold_len;
        end
        rd_out_ready = (hold_left == 0);
        if (hold_left > 0)
            hold_left--;

        rd_rsp_valid    = 1'b0;
        wr_rsp_valid    = 1'b0;
        fence_rsp_valid = 1'b0;
        if ((rd_due.size() != 0) && (rd_due[0] <= mem_cycle))
        begin
            rd_due.delete(0);
            rd_rsp_valid = 1'b1;
        end
        if ((wr_due.size() != 0) && (wr_due[0] <= mem_cycle))
        begin
            wr_due.delete(0);
            wr_rsp_valid = 1'b1;
            wr_outstanding--;
        end
        if ((fence_due.size() != 0) && (fence_due[0] <= mem_cycle))
        begin
            fence_due.delete(0);
            fence_rsp_valid = 1'b1;
        end

        #25;
        if (!reset)
            watch_outputs();
    end

    // ==================================================
    // Clock and timeout
    // ==================================================

    initial
    begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("ERROR at %0t: run did not finish within %0d cycles", $time, cycle_limit);
            abort_run();
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    // Each request task starts on a falling edge and returns on the falling
    // edge after its transfer, so requests can follow back to back
    task automatic send_read(int k);
        rd_in_valid   = 1'b1;
        rd_in_addr    = addr_list[k];
        rd_in_vc      = t_vc'(vc_list[k]);
        rd_in_payload = rd_payload_of(k);
        #25;
        while (!rd_in_ready)
        begin
            @(negedge clk);
            #25;
        end
        @(negedge clk);
        rd_in_valid = 1'b0;
    endtask

    task automatic send_write(int k);
        wr_in_valid   = 1'b1;
        wr_in_addr    = addr_list[k];
        wr_in_vc      = t_vc'(vc_list[k]);
        wr_in_payload = wr_payload_of(k);
        #25;
        while (!wr_in_ready)
        begin
            @(negedge clk);
            #25;
        end
        @(negedge clk);
        wr_in_valid = 1'b0;
    endtask

    // Ratio from the address column, enable from the channel column
    task automatic send_cfg(int k);
        cfg_valid      = 1'b1;
        cfg_ratio      = t_ratio'(addr_list[k]);
        cfg_map_enable = (vc_list[k] != 0);
        #25;
        while (!cfg_ready)
        begin
            @(negedge clk);
            #25;
        end
        @(negedge clk);
        cfg_valid = 1'b0;
        if (exp_list[k] != 0)
            changes_requested++;
    endtask

    task automatic hold_read_ready(int k);
        #25;
        hold_len = int'(addr_list[k]);
        hold_id++;
        @(negedge clk);
    endtask

    initial
    begin
        int          fd;
        int          op;
        int          vcn;
        int          expn;
        int          i;
        logic [31:0] a;
        logic [31:0] v;
        string       line;

        reset          = 1'b1;
        rd_in_valid    = 1'b0;
        rd_in_addr     = '0;
        rd_in_vc       = VC_VA;
        rd_in_payload  = '0;
        wr_in_valid    = 1'b0;
        wr_in_addr     = '0;
        wr_in_vc       = VC_VA;
        wr_in_payload  = '0;
        cfg_valid      = 1'b0;
        cfg_ratio      = '0;
        cfg_map_enable = 1'b0;

        fd = $fopen("verif/vc_map_stim.txt", "r");
        if (fd == 0)
            report_error("cannot open verif/vc_map_stim.txt");
        while ($fgets(line, fd) != 0)
        begin
            if ((line.len() > 1) && (line.getc(0) != "#"))
            begin
                if ($sscanf(line, "%d %h %d %h %d", op, a, vcn, v, expn) != 5)
                    report_error("a stimulus line does not have five columns");
                if (op == OP_RD)
                    rd_ops.push_back(op_list.size());
                if (op == OP_WR)
                    wr_ops.push_back(op_list.size());
                op_list.push_back(op);
                addr_list.push_back(a);
                vc_list.push_back(vcn);
                val_list.push_back(v);
                exp_list.push_back(expn);
            end
        end
        $fclose(fd);
        cycle_limit = 40 * op_list.size() + 200;

        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Idle state straight after reset
        #25;
        check_bit("cfg_ready after reset", 1'b1, cfg_ready);
        check_bit("rd_in_ready after reset", 1'b1, rd_in_ready);
        check_bit("rd_out_valid after reset", 1'b0, rd_out_valid);
        check_bit("wr_out_valid after reset", 1'b0, wr_out_valid);
        check_bit("fence_valid after reset", 1'b0, fence_valid);
        check_bit("map_changed after reset", 1'b0, map_changed);
        @(negedge clk);

        for (i = 0; i < op_list.size(); i++)
        begin
            case (op_list[i])
                OP_RD:   send_read(i);
                OP_WR:   send_write(i);
                OP_CFG:  send_cfg(i);
                OP_HOLD: hold_read_ready(i);
                default: report_error("unknown operation code in stimulus");
            endcase
        end

        // Let every request leave and every response come back
        do
        begin
            @(posedge clk);
        end
        while ((rd_ptr != rd_ops.size()) || (wr_ptr != wr_ops.size()) ||
               (rd_due.size() != 0) || (wr_due.size() != 0) ||
               (fence_due.size() != 0) || (changes_seen != changes_requested));

        check_bit("one fence per ratio change", 1'b1, fences_seen == changes_requested);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== hdl/vc_map_top.sv ====
`timescale 1ns/1ps

`include "vc_map_cfg.svh"

// Request channel mapper with separate read and write paths
module vc_map_top
    import vc_map_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // ==================================================
    // Read requests
    // ==================================================
    input  logic        rd_in_valid,
    output logic        rd_in_ready,
    input  t_addr       rd_in_addr,
    input  t_vc         rd_in_vc,
    input  t_rd_payload rd_in_payload,

    output logic        rd_out_valid,
    input  logic        rd_out_ready,
    output t_addr       rd_out_addr,
    output t_vc         rd_out_vc,
    output t_rd_payload rd_out_payload,

    // ==================================================
    // Write requests
    // ==================================================
    input  logic        wr_in_valid,
    output logic        wr_in_ready,
    input  t_addr       wr_in_addr,
    input  t_vc         wr_in_vc,
    input  t_wr_payload wr_in_payload,

    output logic        wr_out_valid,
    input  logic        wr_out_ready,
    output t_addr       wr_out_addr,
    output t_vc         wr_out_vc,
    output t_wr_payload wr_out_payload,

    // Response pulses from memory
    input  logic        rd_rsp_valid,
    input  logic        wr_rsp_valid,

    // Fence channel
    output logic        fence_valid,
    input  logic        fence_ready,
    input  logic        fence_rsp_valid,

    // Configuration and event
    input  logic        cfg_valid,
    output logic        cfg_ready,
    input  t_ratio      cfg_ratio,
    input  logic        cfg_map_enable,
    output logic        map_changed
);

    t_ratio ratio;
    logic   map_enable;
    logic   block;
    logic   rd_busy;
    logic   wr_busy;
    logic   rd_active;
    logic   wr_active;

    vc_map_ctrl u_ctrl
    (
        .clk             (clk),
        .reset           (reset),
        .cfg_valid       (cfg_valid),
        .cfg_ready       (cfg_ready),
        .cfg_ratio       (cfg_ratio),
        .cfg_map_enable  (cfg_map_enable),
        .rd_busy         (rd_busy),
        .wr_busy         (wr_busy),
        .rd_active       (rd_active),
        .wr_active       (wr_active),
        .fence_valid     (fence_valid),
        .fence_ready     (fence_ready),
        .fence_rsp_valid (fence_rsp_valid),
        .ratio           (ratio),
        .map_enable      (map_enable),
        .block           (block),
        .map_changed     (map_changed)
    );

    vc_map_stage #(.t_payload(t_rd_payload)) u_rd_stage
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (rd_in_valid),
        .in_ready    (rd_in_ready),
        .in_addr     (rd_in_addr),
        .in_vc       (rd_in_vc),
        .in_payload  (rd_in_payload),
        .out_valid   (rd_out_valid),
        .out_ready   (rd_out_ready),
        .out_addr    (rd_out_addr),
        .out_vc      (rd_out_vc),
        .out_payload (rd_out_payload),
        .ratio       (ratio),
        .map_enable  (map_enable),
        .block       (block),
        .busy        (rd_busy)
    );

    vc_map_stage #(.t_payload(t_wr_payload)) u_wr_stage
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (wr_in_valid),
        .in_ready    (wr_in_ready),
        .in_addr     (wr_in_addr),
        .in_vc       (wr_in_vc),
        .in_payload  (wr_in_payload),
        .out_valid   (wr_out_valid),
        .out_ready   (wr_out_ready),
        .out_addr    (wr_out_addr),
        .out_vc      (wr_out_vc),
        .out_payload (wr_out_payload),
        .ratio       (ratio),
        .map_enable  (map_enable),
        .block       (block),
        .busy        (wr_busy)
    );

    // Requests are counted when they leave toward memory
    req_tracker #(.MAX_ACTIVE(`VC_MAP_MAX_ACTIVE)) u_rd_tracker
    (
        .clk      (clk),
        .reset    (reset),
        .note_req (rd_out_valid && rd_out_ready),
        .note_rsp (rd_rsp_valid),
        .active   (rd_active)
    );

    req_tracker #(.MAX_ACTIVE(`VC_MAP_MAX_ACTIVE)) u_wr_tracker
    (
        .clk      (clk),
        .reset    (reset),
        .note_req (wr_out_valid && wr_out_ready),
        .note_rsp (wr_rsp_valid),
        .active   (wr_active)
    );

endmodule

// ==== hdl/vc_map_ctrl.sv ====
`timescale 1ns/1ps

`include "vc_map_cfg.svh"

// Owns the mapping ratio and enable, and runs the fence sequence that
// makes a ratio change safe for requests already in flight
module vc_map_ctrl
    import vc_map_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    // Configuration handshake
    input  logic   cfg_valid,
    output logic   cfg_ready,
    input  t_ratio cfg_ratio,
    input  logic   cfg_map_enable,

    // Activity of the two stages and of the outstanding request counters
    input  logic   rd_busy,
    input  logic   wr_busy,
    input  logic   rd_active,
    input  logic   wr_active,

    // Fence request and its response pulse
    output logic   fence_valid,
    input  logic   fence_ready,
    input  logic   fence_rsp_valid,

    // Configuration in force, sent to both stages
    output t_ratio ratio,
    output logic   map_enable,
    output logic   block,

    // One-cycle event when a new ratio takes effect
    output logic   map_changed
);

    localparam int DELAY_W = $clog2(`VC_MAP_FENCE_DELAY + 1);
    localparam logic [DELAY_W-1:0] DELAY_MAX = DELAY_W'(`VC_MAP_FENCE_DELAY);

    t_map_state       state;
    t_ratio           pend_ratio;
    logic             pend_enable;
    logic [DELAY_W-1:0] delay_cnt;
    logic             drained;

    // Configuration is only taken while no sequence is running
    assign cfg_ready = (state == IDLE);

    // Writes must have retired before the fence, otherwise it would not
    // order them against requests mapped with the new ratio
    assign drained = !rd_busy && !wr_busy && !wr_active && (delay_cnt == DELAY_MAX);

    // ==================================================
    // Fence delay timer
    // ==================================================

    // Counts up in DRAIN and holds once it reaches the delay
    always_ff @(posedge clk)
    begin
        if (reset || (state != DRAIN))
        begin
            delay_cnt <= '0;
        end
        else if (delay_cnt != DELAY_MAX)
        begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    // ==================================================
    // State machine
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= IDLE;
            ratio       <= t_ratio'(`VC_MAP_RATIO_DEFAULT);
            map_enable  <= 1'b1;
            block       <= 1'b0;
            fence_valid <= 1'b0;
            map_changed <= 1'b0;
        end
        else
        begin
            // The event is a single pulse unless set again below
            map_changed <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (cfg_valid)
                    begin
                        if (cfg_ratio != ratio)
                        begin
                            // A new ratio moves addresses between channels
                            // so traffic stops until all channels agree
                            block <= 1'b1;
                            state <= DRAIN;
                        end
                        else
                        begin
                            // Enable alone takes effect at once, and an
                            // unchanged value simply rewrites itself
                            map_enable <= cfg_map_enable;
                        end
                    end
                end

                DRAIN:
                begin
                    if (drained)
                    begin
                        fence_valid <= 1'b1;
                        state       <= EMIT_FENCE;
                    end
                end

                EMIT_FENCE:
                begin
                    if (fence_ready)
                    begin
                        fence_valid <= 1'b0;
                        state       <= WAIT_FENCE_RSP;
                    end
                end

                WAIT_FENCE_RSP:
                begin
                    if (fence_rsp_valid)
                    begin
                        ratio       <= pend_ratio;
                        map_enable  <= pend_enable;
                        map_changed <= 1'b1;
                        state       <= WAIT_QUIET;
                    end
                end

                WAIT_QUIET:
                begin
                    // Reads issued under the old ratio must finish first
                    if (!rd_active)
                    begin
                        block <= 1'b0;
                        state <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Pending configuration is captured on every accepted cfg transfer
    always_ff @(posedge clk)
    begin
        if (cfg_valid && cfg_ready)
        begin
            pend_ratio  <= cfg_ratio;
            pend_enable <= cfg_map_enable;
        end
    end

    a_fence_in_state: assert property (@(posedge clk) disable iff (reset)
        fence_valid |-> (state == EMIT_FENCE));

    a_changed_pulse: assert property (@(posedge clk) disable iff (reset)
        map_changed |=> !map_changed);

endmodule

// ==== hdl/req_tracker.sv ====
`timescale 1ns/1ps

`include "vc_map_cfg.svh"

// Counts requests that were issued on one channel and not yet answered
module req_tracker
#(
    parameter int MAX_ACTIVE = `VC_MAP_MAX_ACTIVE
)
(
    input  logic clk,
    input  logic reset,

    // One pulse per issued request and one per returned response
    input  logic note_req,
    input  logic note_rsp,

    // Low only when nothing is outstanding
    output logic active
);

    localparam int CNT_W = $clog2(MAX_ACTIVE + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count  <= '0;
            active <= 1'b0;
        end
        else
        begin
            // A request and a response in the same cycle leave the count as is
            if (note_req && !note_rsp)
            begin
                count <= count + 1'b1;
            end
            else if (!note_req && note_rsp)
            begin
                count <= count - 1'b1;
            end

            // Rises right after an issue and falls one cycle after the count
            // reaches zero, so the flag never claims idle too early
            active <= (count != '0) || note_req;
        end
    end

    // The memory side never answers a request that was not issued
    a_no_orphan_rsp: assert property (@(posedge clk) disable iff (reset)
        note_rsp |-> (count != '0));

    // The requester side keeps within the outstanding limit
    a_max_active: assert property (@(posedge clk) disable iff (reset)
        !((count == CNT_W'(MAX_ACTIVE)) && note_req && !note_rsp));

endmodule

// ==== hdl/vc_map_stage.sv ====
`timescale 1ns/1ps

// Registered valid/ready stage that replaces the VA channel of a request
// with a physical channel chosen from a hash of the address
module vc_map_stage
    import vc_map_pkg::*;
#(
    parameter type t_payload = t_rd_payload
)
(
    input  logic     clk,
    input  logic     reset,

    // Request from the requester side
    input  logic     in_valid,
    output logic     in_ready,
    input  t_addr    in_addr,
    input  t_vc      in_vc,
    input  t_payload in_payload,

    // Request toward memory, with its channel already decided
    output logic     out_valid,
    input  logic     out_ready,
    output t_addr    out_addr,
    output t_vc      out_vc,
    output t_payload out_payload,

    // Mapping configuration from the controller
    input  t_ratio   ratio,
    input  logic     map_enable,
    input  logic     block,

    // High while the register holds a request
    output logic     busy
);

    // ==================================================
    // Address hash
    // ==================================================

    // Fold the address into six bits so that one address always lands on
    // the same channel, whatever order the requests come in
    // The top two address bits form a short sixth field
    function automatic t_ratio hash_idx(t_addr a);
        return a[5:0] ^ a[11:6] ^ a[17:12] ^ a[23:18] ^ a[29:24] ^ {4'b0000, a[31:30]};
    endfunction

    t_ratio in_idx;
    t_vc    map_vc;
    logic   accept;

    always_comb
    begin
        in_idx = hash_idx(in_addr);
        map_vc = in_vc;

        // Only VA requests are remapped, and only while mapping is on
        if (map_enable && (in_vc == VC_VA))
        begin
            if (in_idx < ratio)
            begin
                map_vc = VC_VL0;
            end
            else
            begin
                // Split the rest evenly between the two high bandwidth links
                map_vc = in_idx[0] ? VC_VH0 : VC_VH1;
            end
        end
    end

    // ==================================================
    // Output register
    // ==================================================

    // Take a new request when the register is empty or drains this cycle
    // The controller closes the input while it changes the ratio
    assign in_ready = !block && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;
    assign busy     = out_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else if (accept)
        begin
            out_valid <= 1'b1;
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;
        end
    end

    // The channel is fixed here with the ratio in force at acceptance
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out_addr    <= in_addr;
            out_vc      <= map_vc;
            out_payload <= in_payload;
        end
    end

    // A stalled request must not change under the receiver
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_addr) &&
                                    $stable(out_vc) && $stable(out_payload));

endmodule

// ==== hdl/vc_map_pkg.sv ====
`include "vc_map_cfg.svh"

package vc_map_pkg;

    // ==================================================
    // Channel codes
    // ==================================================

    // VA is virtual and is replaced with one of the three physical channels
    // VL0 is the low latency link, VH0 and VH1 are the two high bandwidth links
    typedef enum logic [1:0]
    {
        VC_VA  = 2'd0,
        VC_VL0 = 2'd1,
        VC_VH0 = 2'd2,
        VC_VH1 = 2'd3
    } t_vc;

    // ==================================================
    // Request fields
    // ==================================================

    typedef logic [`VC_MAP_ADDR_W-1:0] t_addr;

    // Fraction of VA requests that go to VL0, in sixty-fourths
    typedef logic [`VC_MAP_RATIO_W-1:0] t_ratio;

    // Read requests carry only the tag used to match the response
    typedef struct packed
    {
        logic [`VC_MAP_TAG_W-1:0] tag;
    } t_rd_payload;

    // Write requests carry the tag and the data word
    typedef struct packed
    {
        logic [`VC_MAP_TAG_W-1:0]  tag;
        logic [`VC_MAP_DATA_W-1:0] data;
    } t_wr_payload;

    // ==================================================
    // Mapping controller
    // ==================================================

    // IDLE accepts configuration, the other states run the fence sequence
    // DRAIN waits for writes to retire, EMIT_FENCE offers the fence,
    // WAIT_FENCE_RSP waits for its answer and WAIT_QUIET lets reads settle
    typedef enum logic [2:0]
    {
        IDLE,
        DRAIN,
        EMIT_FENCE,
        WAIT_FENCE_RSP,
        WAIT_QUIET
    } t_map_state;

endpackage

// ==== include/vc_map_cfg.svh ====
`ifndef VC_MAP_CFG_SVH
`define VC_MAP_CFG_SVH

// ==================================================
// Widths of the request fields
// ==================================================

// Byte address carried by every read and write request
`define VC_MAP_ADDR_W 32

// Tag that the requester uses to match responses
`define VC_MAP_TAG_W 8

// Write data carried next to the tag
`define VC_MAP_DATA_W 32

// ==================================================
// Channel mapping defaults and limits
// ==================================================

// Share of VA traffic sent to VL0, counted in sixty-fourths
`define VC_MAP_RATIO_W 6

// Ratio in force after reset gives 16:24:24 over VL0, VH0 and VH1
`define VC_MAP_RATIO_DEFAULT 16

// Largest number of issued but unanswered requests on one channel
`define VC_MAP_MAX_ACTIVE 128

// Cycles spent in DRAIN before the fence may leave
`define VC_MAP_FENCE_DELAY 8

`endif
